// ==== source/lpif_defs.svh ====
/*
  Shared widths for the two-lane streaming link
  Lane layout, flit and user field sizes, Wishbone register map
*/
`ifndef LPIF_DEFS_SVH
`define LPIF_DEFS_SVH

// PHY lane word layout
`define LPIF_LANE_W          80
`define LPIF_LANE_PAYLOAD_W  75
`define LPIF_STB_BIT         75
`define LPIF_MRK_BIT         76

// Flit and user field widths
`define LPIF_FLIT_W          150
`define LPIF_DATA_W          128
`define LPIF_STATE_W         8
`define LPIF_PROTID_W        4
`define LPIF_DVALID_W        2
`define LPIF_CRC_W           4
`define LPIF_CRC_VALID_W     2
`define LPIF_VALID_W         2
`define LPIF_DELAY_W         16

// Wishbone bus and word offsets
`define LPIF_WB_ADR_W        3
`define LPIF_WB_DAT_W        32
`define LPIF_ADDR_DELAY_X    3'd0
`define LPIF_ADDR_DELAY_Y    3'd1
`define LPIF_ADDR_DELAY_Z    3'd2
`define LPIF_ADDR_CTRL       3'd3
`define LPIF_ADDR_STATUS     3'd4

`endif

// ==== source/lpif_pkg.sv ====
/*
  Link types: user stream fields, flit vector,
  configuration from the register block, sync flags
*/
package lpif_pkg;

`include "lpif_defs.svh"

  ////////////////////////////////////////
  // User stream, one flit worth of fields
  ////////////////////////////////////////

  // First field lands in the flit MSBs
  typedef struct packed {
    logic [`LPIF_STATE_W-1:0]     state;
    logic [`LPIF_PROTID_W-1:0]    protid;
    logic [`LPIF_DATA_W-1:0]      data;
    logic [`LPIF_DVALID_W-1:0]    dvalid;
    logic [`LPIF_CRC_W-1:0]       crc;
    logic [`LPIF_CRC_VALID_W-1:0] crc_valid;
    logic [`LPIF_VALID_W-1:0]     valid;
  } lpif_stream_t;

  // Flit as carried across both lanes
  typedef logic [`LPIF_FLIT_W-1:0] lpif_flit_t;

  ////////////////////////////////////////
  // Control between blocks
  ////////////////////////////////////////

  // Programmed through Wishbone
  typedef struct packed {
    logic [`LPIF_DELAY_W-1:0] delay_x;
    logic [`LPIF_DELAY_W-1:0] delay_y;
    logic [`LPIF_DELAY_W-1:0] delay_z;
    logic                     gen2_mode;
  } lpif_cfg_t;

  // Sync bits and delayed online flags
  typedef struct packed {
    logic stb;
    logic mrk;
    logic tx_online_delay;
    logic rx_online_delay;
  } lpif_sync_t;

endpackage

// ==== source/lpif_auto_sync.sv ====
/*
  Auto sync for the link
  Online delay counters for both directions,
  strobe and marker bit generation
*/
`include "lpif_defs.svh"
`timescale 1ns/100ps

module lpif_auto_sync import lpif_pkg::*; (
  input  logic       clk_wr,
  input  logic       rst_n,
  input  lpif_cfg_t  cfg,
  input  logic       tx_online,
  input  logic       rx_online,
  output lpif_sync_t sync
);

  // Extra bit holds the y + z sum
  logic [`LPIF_DELAY_W:0]   tx_target;
  logic [`LPIF_DELAY_W:0]   tx_cnt;
  logic [`LPIF_DELAY_W-1:0] rx_cnt;
  logic                     tx_delay_q;
  logic                     rx_delay_q;
  // High on every second word after tx_online rises
  logic                     word_odd;

  assign tx_target = {1'b0, cfg.delay_y} + {1'b0, cfg.delay_z};

  ////////////////////////////////////////
  // Tx online delay
  ////////////////////////////////////////

  // Counter parks at the target, flag follows one cycle later
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_cnt     <= '0;
      tx_delay_q <= 1'b0;
    end else if (!tx_online) begin
      tx_cnt     <= '0;
      tx_delay_q <= 1'b0;
    end else begin
      if (tx_cnt < tx_target)
        tx_cnt <= tx_cnt + 1'b1;
      tx_delay_q <= (tx_cnt >= tx_target);
    end
  end

  ////////////////////////////////////////
  // Rx online delay
  ////////////////////////////////////////

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      rx_cnt     <= '0;
      rx_delay_q <= 1'b0;
    end else if (!rx_online) begin
      rx_cnt     <= '0;
      rx_delay_q <= 1'b0;
    end else begin
      if (rx_cnt < cfg.delay_x)
        rx_cnt <= rx_cnt + 1'b1;
      rx_delay_q <= (rx_cnt >= cfg.delay_x);
    end
  end

  // Word parity, restarts at even on each tx_online rise
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n)
      word_odd <= 1'b0;
    else
      word_odd <= tx_online & ~word_odd;
  end

  // Gen1 marks every word, gen2 only the even ones
  always_comb begin
    sync.stb             = tx_online;
    sync.mrk             = tx_online & (~cfg.gen2_mode | ~word_odd);
    sync.tx_online_delay = tx_delay_q;
    sync.rx_online_delay = rx_delay_q;
  end

endmodule

// ==== source/lpif_field_map.sv ====
/*
  Field mapper
  Packs upstream user fields into a flit,
  unpacks and registers accepted receive flits
*/
`include "lpif_defs.svh"
`timescale 1ns/100ps

module lpif_field_map import lpif_pkg::*; (
  input  logic         clk_wr,
  input  logic         rst_n,
  input  lpif_stream_t ustrm,
  output lpif_flit_t   tx_flit,
  input  lpif_flit_t   rx_flit,
  input  logic         rx_accept,
  output lpif_stream_t dstrm
);

  lpif_stream_t                 rx_fields;
  // Qualifiers, cleared on idle words
  logic [`LPIF_VALID_W-1:0]     valid_q;
  logic [`LPIF_DVALID_W-1:0]    dvalid_q;
  logic [`LPIF_CRC_VALID_W-1:0] crc_valid_q;
  // Payload fields hold between accepted flits
  logic [`LPIF_STATE_W-1:0]     state_q;
  logic [`LPIF_PROTID_W-1:0]    protid_q;
  logic [`LPIF_DATA_W-1:0]      data_q;
  logic [`LPIF_CRC_W-1:0]       crc_q;

  // Transmit packing, state in the top bits
  assign tx_flit = {ustrm.state, ustrm.protid, ustrm.data, ustrm.dvalid,
                    ustrm.crc, ustrm.crc_valid, ustrm.valid};

  // Same order on the way back
  assign rx_fields = lpif_stream_t'(rx_flit);

  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      valid_q     <= '0;
      dvalid_q    <= '0;
      crc_valid_q <= '0;
    end else begin
      valid_q     <= rx_accept ? rx_fields.valid : '0;
      dvalid_q    <= rx_accept ? rx_fields.dvalid : '0;
      crc_valid_q <= rx_accept ? rx_fields.crc_valid : '0;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rx_accept) begin
      state_q  <= rx_fields.state;
      protid_q <= rx_fields.protid;
      data_q   <= rx_fields.data;
      crc_q    <= rx_fields.crc;
    end
  end

  assign dstrm = '{state: state_q, protid: protid_q, data: data_q, dvalid: dvalid_q,
                   crc: crc_q, crc_valid: crc_valid_q, valid: valid_q};

endmodule

// ==== source/lpif_lane_concat.sv ====
/*
  Lane concatenator
  Splits the tx flit over two PHY lanes with strobe and marker,
  rebuilds the rx flit and qualifies it on both strobes
*/
`include "lpif_defs.svh"
`timescale 1ns/100ps

module lpif_lane_concat import lpif_pkg::*; (
  input  logic                    clk_wr,
  input  logic                    rst_n,
  input  lpif_sync_t              sync,
  input  lpif_flit_t              tx_flit,
  output lpif_flit_t              rx_flit,
  output logic                    rx_accept,
  output logic [`LPIF_LANE_W-1:0] tx_phy0,
  output logic [`LPIF_LANE_W-1:0] tx_phy1,
  input  logic [`LPIF_LANE_W-1:0] rx_phy0,
  input  logic [`LPIF_LANE_W-1:0] rx_phy1,
  output logic                    tx_count_inc,
  output logic                    rx_count_inc
);

  logic [`LPIF_LANE_PAYLOAD_W-1:0] tx_pay0;
  logic [`LPIF_LANE_PAYLOAD_W-1:0] tx_pay1;
  logic [`LPIF_LANE_W-1:0]         tx_word0;
  logic [`LPIF_LANE_W-1:0]         tx_word1;
  // Marks a payload word on the lanes
  logic                            tx_sent_q;

  // Payload in the low bits, sync bits above, top bits spare
  function automatic logic [`LPIF_LANE_W-1:0] lane_word(
    input logic [`LPIF_LANE_PAYLOAD_W-1:0] payload,
    input logic                            stb,
    input logic                            mrk
  );
    logic [`LPIF_LANE_W-1:0] word;
    word                                 = '0;
    word[`LPIF_LANE_PAYLOAD_W-1:0]       = payload;
    word[`LPIF_STB_BIT]                  = stb;
    word[`LPIF_MRK_BIT]                  = mrk;
    return word;
  endfunction

  ////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////

  // Zero payload until the tx delay has passed
  assign tx_pay0 = sync.tx_online_delay ? tx_flit[`LPIF_LANE_PAYLOAD_W-1:0] : '0;
  assign tx_pay1 = sync.tx_online_delay ?
                   tx_flit[`LPIF_FLIT_W-1:`LPIF_LANE_PAYLOAD_W] : '0;

  // Both lanes carry the same sync bits
  assign tx_word0 = lane_word(tx_pay0, sync.stb, sync.mrk);
  assign tx_word1 = lane_word(tx_pay1, sync.stb, sync.mrk);

  // Single register stage to the PHY
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_phy0   <= '0;
      tx_phy1   <= '0;
      tx_sent_q <= 1'b0;
    end else begin
      tx_phy0   <= tx_word0;
      tx_phy1   <= tx_word1;
      tx_sent_q <= sync.tx_online_delay;
    end
  end

  // One count per word that left with payload
  assign tx_count_inc = tx_sent_q;

  ////////////////////////////////////////
  // Receive
  ////////////////////////////////////////

  // Lane 1 carries the upper flit half
  assign rx_flit = {rx_phy1[`LPIF_LANE_PAYLOAD_W-1:0], rx_phy0[`LPIF_LANE_PAYLOAD_W-1:0]};

  // Both strobes needed, after the rx delay
  assign rx_accept = sync.rx_online_delay & rx_phy0[`LPIF_STB_BIT] & rx_phy1[`LPIF_STB_BIT];

  // Counted on the same edge the mapper registers it
  assign rx_count_inc = rx_accept;

endmodule

// ==== source/lpif_wb_cfg.sv ====
/*
  Wishbone classic slave
  Delay, control and status registers,
  saturating tx and rx flit counters
*/
`include "lpif_defs.svh"
`timescale 1ns/100ps

module lpif_wb_cfg import lpif_pkg::*; (
  input  logic                      clk_wr,
  input  logic                      rst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`LPIF_WB_ADR_W-1:0] wb_adr,
  input  logic [`LPIF_WB_DAT_W-1:0] wb_dat_i,
  output logic [`LPIF_WB_DAT_W-1:0] wb_dat_o,
  output logic                      wb_ack,
  output lpif_cfg_t                 cfg,
  input  logic                      tx_count_inc,
  input  logic                      rx_count_inc
);

  // New cycle seen, not yet acked
  logic                      wb_req;
  logic [`LPIF_WB_DAT_W-1:0] rd_data;
  logic [`LPIF_DELAY_W-1:0]  tx_flits;
  logic [`LPIF_DELAY_W-1:0]  rx_flits;

  assign wb_req = wb_cyc & wb_stb & ~wb_ack;

  ////////////////////////////////////////
  // Bus handshake and register writes
  ////////////////////////////////////////

  // Ack is a one-cycle pulse, write lands with it
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack <= 1'b0;
      cfg    <= '0;
    end else begin
      wb_ack <= wb_req;
      if (wb_req && wb_we) begin
        case (wb_adr)
          `LPIF_ADDR_DELAY_X: cfg.delay_x   <= wb_dat_i[`LPIF_DELAY_W-1:0];
          `LPIF_ADDR_DELAY_Y: cfg.delay_y   <= wb_dat_i[`LPIF_DELAY_W-1:0];
          `LPIF_ADDR_DELAY_Z: cfg.delay_z   <= wb_dat_i[`LPIF_DELAY_W-1:0];
          `LPIF_ADDR_CTRL:    cfg.gen2_mode <= wb_dat_i[0];
          // Status is read only
          default: ;
        endcase
      end
    end
  end

  // Read mux, unused offsets read zero
  always_comb begin
    case (wb_adr)
      `LPIF_ADDR_DELAY_X: rd_data = {16'h0, cfg.delay_x};
      `LPIF_ADDR_DELAY_Y: rd_data = {16'h0, cfg.delay_y};
      `LPIF_ADDR_DELAY_Z: rd_data = {16'h0, cfg.delay_z};
      `LPIF_ADDR_CTRL:    rd_data = {31'h0, cfg.gen2_mode};
      `LPIF_ADDR_STATUS:  rd_data = {rx_flits, tx_flits};
      default:            rd_data = '0;
    endcase
  end

  // Valid while ack is high
  always_ff @(posedge clk_wr) begin
    if (wb_req && !wb_we)
      wb_dat_o <= rd_data;
  end

  // Flit counters stick at all ones
  always_ff @(posedge clk_wr or negedge rst_n) begin
    if (!rst_n) begin
      tx_flits <= '0;
      rx_flits <= '0;
    end else begin
      if (tx_count_inc && tx_flits != '1)
        tx_flits <= tx_flits + 1'b1;
      if (rx_count_inc && rx_flits != '1)
        rx_flits <= rx_flits + 1'b1;
    end
  end

endmodule

// ==== source/lpif_link_top.sv ====
/*
  Link top level
  Register block, auto sync, field mapper, lane concatenator
*/
`include "lpif_defs.svh"
`timescale 1ns/100ps

module lpif_link_top import lpif_pkg::*; (
  input  logic                      clk_wr,
  input  logic                      rst_n,
  // Link bring-up
  input  logic                      tx_online,
  input  logic                      rx_online,
  // Wishbone configuration port
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`LPIF_WB_ADR_W-1:0] wb_adr,
  input  logic [`LPIF_WB_DAT_W-1:0] wb_dat_i,
  output logic [`LPIF_WB_DAT_W-1:0] wb_dat_o,
  output logic                      wb_ack,
  // PHY lanes
  output logic [`LPIF_LANE_W-1:0]   tx_phy0,
  output logic [`LPIF_LANE_W-1:0]   tx_phy1,
  input  logic [`LPIF_LANE_W-1:0]   rx_phy0,
  input  logic [`LPIF_LANE_W-1:0]   rx_phy1,
  // User streams
  input  lpif_stream_t              ustrm,
  output lpif_stream_t              dstrm
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  lpif_cfg_t  cfg;
  lpif_sync_t sync;
  lpif_flit_t tx_flit;
  lpif_flit_t rx_flit;
  logic       rx_accept;
  logic       tx_count_inc;
  logic       rx_count_inc;

  // Registers and flit counters
  lpif_wb_cfg cfg_regs (
    .clk_wr, .rst_n,
    .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_i, .wb_dat_o, .wb_ack,
    .cfg, .tx_count_inc, .rx_count_inc
  );

  // Online delays and sync bits
  lpif_auto_sync auto_sync (
    .clk_wr, .rst_n, .cfg, .tx_online, .rx_online, .sync
  );

  // User fields to and from flits
  lpif_field_map field_map (
    .clk_wr, .rst_n, .ustrm, .tx_flit, .rx_flit, .rx_accept, .dstrm
  );

  // Flits to and from the two lanes
  lpif_lane_concat lane_concat (
    .clk_wr, .rst_n, .sync, .tx_flit, .rx_flit, .rx_accept,
    .tx_phy0, .tx_phy1, .rx_phy0, .rx_phy1,
    .tx_count_inc, .rx_count_inc
  );

endmodule

// ==== bench/lpif_link_tb.sv ====
/*
  Loopback testbench for the two-lane link
  Stimulus table, Wishbone tasks, lane and stream checks, watchdog
*/
`include "lpif_defs.svh"
`timescale 1ns/100ps

module lpif_link_tb import lpif_pkg::*; ();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 10;
  localparam int N_ROWS       = 5;
  localparam int MAX_WORDS    = 64;
  localparam int ACK_LIMIT    = 16;
  // Covers Wishbone traffic and idle cycles of one row
  localparam int ROW_MARGIN   = 120;
  localparam int RUN_MARGIN   = 200;

  typedef struct {
    string name;
    logic  gen2;
    int    delay_x;
    int    delay_y;
    int    delay_z;
    int    length;
  } row_t;

  // Name, gen2_mode, delay_x, delay_y, delay_z, stream length
  row_t rows [N_ROWS] = '{
    '{"gen1_zero_delay", 1'b0, 0, 0, 0, 10},
    '{"gen1_rx_slow",    1'b0, 9, 1, 2, 12},
    '{"gen2_tx_slow",    1'b1, 2, 5, 6, 14},
    '{"gen2_mixed",      1'b1, 4, 2, 1, 9},
    '{"gen1_long",       1'b0, 3, 0, 3, 20}
  };

  logic                      clk_wr;
  logic                      rst_n;
  logic                      tx_online;
  logic                      rx_online;
  logic                      wb_cyc;
  logic                      wb_stb;
  logic                      wb_we;
  logic [`LPIF_WB_ADR_W-1:0] wb_adr;
  logic [`LPIF_WB_DAT_W-1:0] wb_dat_i;
  logic [`LPIF_WB_DAT_W-1:0] wb_dat_o;
  logic                      wb_ack;
  logic [`LPIF_LANE_W-1:0]   tx_phy0;
  logic [`LPIF_LANE_W-1:0]   tx_phy1;
  logic [`LPIF_LANE_W-1:0]   rx_phy0;
  logic [`LPIF_LANE_W-1:0]   rx_phy1;
  lpif_stream_t              ustrm;
  lpif_stream_t              dstrm;
  // Bit 0 kills the lane 0 strobe, bit 1 the lane 1 strobe
  logic [1:0]                drop_stb;

  integer       seed = 61636;
  lpif_stream_t words [MAX_WORDS];
  logic [1:0]   drops [MAX_WORDS];
  lpif_stream_t last_acc;
  logic         have_last;
  int           tx_total;
  int           rx_total;
  int           error_count;

  lpif_link_top dut (
    .clk_wr(clk_wr), .rst_n(rst_n), .tx_online(tx_online), .rx_online(rx_online),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
    .wb_dat_i(wb_dat_i), .wb_dat_o(wb_dat_o), .wb_ack(wb_ack),
    .tx_phy0(tx_phy0), .tx_phy1(tx_phy1), .rx_phy0(rx_phy0), .rx_phy1(rx_phy1),
    .ustrm(ustrm), .dstrm(dstrm)
  );

  initial begin
    clk_wr = 1'b0;
    forever #(CLK_PERIOD / 2) clk_wr = ~clk_wr;
  end

  // Lane loopback, strobe can be cleared per lane
  always_comb begin
    rx_phy0 = tx_phy0;
    rx_phy1 = tx_phy1;
    if (drop_stb[0])
      rx_phy0[`LPIF_STB_BIT] = 1'b0;
    if (drop_stb[1])
      rx_phy1[`LPIF_STB_BIT] = 1'b0;
  end

  ////////////////////////////////////////
  // Error reporting
  ////////////////////////////////////////

  task automatic report_mismatch(input string test_name, input string what,
                                 input logic [159:0] expected, input logic [159:0] actual);
    error_count++;
    $display("Fail %s %s expected %h actual %h", test_name, what, expected, actual);
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopped at first mismatch");
  endtask

  task automatic report_error(input string msg);
    error_count++;
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  ////////////////////////////////////////
  // Wishbone master
  ////////////////////////////////////////

  // Sampled on the falling edge, away from the slave's update
  task automatic wait_ack(input string test_name);
    int waited;
    waited = 0;
    @(negedge clk_wr);
    while (wb_ack !== 1'b1) begin
      waited++;
      assert (waited < ACK_LIMIT)
        else report_error({"Wishbone ack never arrived in ", test_name});
      @(negedge clk_wr);
    end
  endtask

  task automatic wb_write(input string test_name, input logic [`LPIF_WB_ADR_W-1:0] adr,
                          input logic [`LPIF_WB_DAT_W-1:0] data);
    @(posedge clk_wr);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= 1'b1;
    wb_adr   <= adr;
    wb_dat_i <= data;
    wait_ack(test_name);
    @(posedge clk_wr);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_read(input string test_name, input logic [`LPIF_WB_ADR_W-1:0] adr,
                         output logic [`LPIF_WB_DAT_W-1:0] data);
    @(posedge clk_wr);
    wb_cyc <= 1'b1;
    wb_stb <= 1'b1;
    wb_we  <= 1'b0;
    wb_adr <= adr;
    wait_ack(test_name);
    data = wb_dat_o;
    @(posedge clk_wr);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  task automatic write_and_verify(input string test_name, input string what,
                                  input logic [`LPIF_WB_ADR_W-1:0] adr,
                                  input logic [`LPIF_WB_DAT_W-1:0] value);
    logic [`LPIF_WB_DAT_W-1:0] got;
    wb_write(test_name, adr, value);
    wb_read(test_name, adr, got);
    assert (got == value) else report_mismatch(test_name, what, 160'(value), 160'(got));
  endtask

  ////////////////////////////////////////
  // Lane and stream checks
  ////////////////////////////////////////

  // Word k left the mapper in cycle k, lanes show it in cycle k + 1
  task automatic check_lanes(input row_t row, input int k, input int tx_start,
                             input int n_cycles);
    lpif_flit_t              payload;
    logic                    stb;
    logic                    mrk;
    logic [`LPIF_LANE_W-1:0] exp0;
    logic [`LPIF_LANE_W-1:0] exp1;
    payload = (k >= tx_start && k <= n_cycles) ? lpif_flit_t'(words[k]) : '0;
    stb     = (k < n_cycles);
    mrk     = stb && (!row.gen2 || (k % 2 == 0));
    exp0    = {3'b000, mrk, stb, payload[`LPIF_LANE_PAYLOAD_W-1:0]};
    exp1    = {3'b000, mrk, stb, payload[`LPIF_FLIT_W-1:`LPIF_LANE_PAYLOAD_W]};
    assert (tx_phy0 == exp0)
      else report_mismatch(row.name, $sformatf("tx_phy0 word %0d", k), 160'(exp0), 160'(tx_phy0));
    assert (tx_phy1 == exp1)
      else report_mismatch(row.name, $sformatf("tx_phy1 word %0d", k), 160'(exp1), 160'(tx_phy1));
  endtask

  // Word k reaches dstrm two cycles after it was driven
  task automatic check_stream(input row_t row, input int k, input int rx_start,
                              input int tx_start, input int n_cycles);
    lpif_stream_t exp_strm;
    logic         accepted;
    accepted = (k >= rx_start) && (k < n_cycles) && (drops[k] == 2'b00);
    if (accepted) begin
      exp_strm = (k >= tx_start) ? words[k] : '0;
      assert (dstrm == exp_strm)
        else report_mismatch(row.name, $sformatf("dstrm word %0d", k),
                             160'(exp_strm), 160'(dstrm));
      last_acc  = exp_strm;
      have_last = 1'b1;
      rx_total++;
    end else begin
      assert ({dstrm.valid, dstrm.dvalid, dstrm.crc_valid} == 6'h0)
        else report_mismatch(row.name, $sformatf("dstrm qualifiers word %0d", k),
                             160'(0), 160'({dstrm.valid, dstrm.dvalid, dstrm.crc_valid}));
      // Payload fields hold the last accepted flit
      if (have_last) begin
        assert ({dstrm.state, dstrm.protid, dstrm.data, dstrm.crc} ==
                {last_acc.state, last_acc.protid, last_acc.data, last_acc.crc})
          else report_mismatch(row.name, $sformatf("held fields word %0d", k),
                               160'(last_acc), 160'(dstrm));
      end
    end
  endtask

  ////////////////////////////////////////
  // One table row
  ////////////////////////////////////////

  task automatic run_row(input row_t row);
    logic [159:0]              rnd;
    logic [31:0]               pick;
    logic [`LPIF_WB_DAT_W-1:0] status;
    logic [`LPIF_WB_DAT_W-1:0] status_after;
    int                        tx_start;
    int                        rx_start;
    int                        n_cycles;

    write_and_verify(row.name, "delay_x", `LPIF_ADDR_DELAY_X, 32'(row.delay_x));
    write_and_verify(row.name, "delay_y", `LPIF_ADDR_DELAY_Y, 32'(row.delay_y));
    write_and_verify(row.name, "delay_z", `LPIF_ADDR_DELAY_Z, 32'(row.delay_z));
    write_and_verify(row.name, "gen2_mode", `LPIF_ADDR_CTRL, {31'h0, row.gen2});

    // Status ignores writes
    wb_read(row.name, `LPIF_ADDR_STATUS, status);
    wb_write(row.name, `LPIF_ADDR_STATUS, ~status);
    wb_read(row.name, `LPIF_ADDR_STATUS, status_after);
    assert (status_after == status)
      else report_mismatch(row.name, "status after write", 160'(status), 160'(status_after));

    // First word index with payload and first accepted index
    tx_start = row.delay_y + row.delay_z + 1;
    rx_start = row.delay_x;
    n_cycles = ((rx_start > tx_start) ? rx_start : tx_start) + row.length;

    for (int c = 0; c <= n_cycles + 2; c++) begin
      rnd      = {$random(seed), $random(seed), $random(seed), $random(seed), $random(seed)};
      words[c] = rnd[`LPIF_FLIT_W-1:0];
      pick     = $random(seed);
      drops[c] = (pick[2:0] == 3'd0) ? (pick[3] ? 2'b10 : 2'b01) : 2'b00;
    end

    // Online for cycles 0 to n_cycles - 1
    for (int c = 0; c <= n_cycles + 2; c++) begin
      @(posedge clk_wr);
      tx_online <= (c < n_cycles);
      rx_online <= (c < n_cycles);
      ustrm     <= words[c];
      drop_stb  <= (c >= 1) ? drops[c-1] : 2'b00;
      @(negedge clk_wr);
      if (c >= 1)
        check_lanes(row, c - 1, tx_start, n_cycles);
      if (c >= 2)
        check_stream(row, c - 2, rx_start, tx_start, n_cycles);
    end

    @(posedge clk_wr);
    drop_stb <= 2'b00;
    repeat (3) @(posedge clk_wr);

    // Payload words run from tx_start up to n_cycles
    tx_total += n_cycles - tx_start + 1;
    wb_read(row.name, `LPIF_ADDR_STATUS, status);
    assert (status == {16'(rx_total), 16'(tx_total)})
      else report_mismatch(row.name, "status counters",
                           160'({16'(rx_total), 16'(tx_total)}), 160'(status));
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    rst_n       <= 1'b0;
    tx_online   <= 1'b0;
    rx_online   <= 1'b0;
    wb_cyc      <= 1'b0;
    wb_stb      <= 1'b0;
    wb_we       <= 1'b0;
    wb_adr      <= '0;
    wb_dat_i    <= '0;
    ustrm       <= '0;
    drop_stb    <= 2'b00;
    have_last   = 1'b0;
    tx_total    = 0;
    rx_total    = 0;
    error_count = 0;

    repeat (RESET_CYCLES) @(posedge clk_wr);
    rst_n <= 1'b1;

    // Outputs quiet out of reset
    @(negedge clk_wr);
    assert (tx_phy0 == '0 && tx_phy1 == '0)
      else report_error("Tx lanes are not zero after reset");
    assert ({dstrm.valid, dstrm.dvalid, dstrm.crc_valid} == 6'h0 && wb_ack == 1'b0)
      else report_error("Stream qualifiers or wb_ack are not zero after reset");

    for (int r = 0; r < N_ROWS; r++)
      run_row(rows[r]);

    if (error_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Budget from the table, delays plus lengths plus margins
  initial begin
    int budget;
    budget = RESET_CYCLES + RUN_MARGIN;
    foreach (rows[i])
      budget += rows[i].delay_x + rows[i].delay_y + rows[i].delay_z + rows[i].length +
                ROW_MARGIN;
    #(budget * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles", budget);
    $display("TESTBENCH FAILED");
    $fatal(1, "Simulation timed out");
  end

endmodule

// ==== sim.f ====
+incdir+source
source/lpif_pkg.sv
source/lpif_auto_sync.sv
source/lpif_field_map.sv
source/lpif_lane_concat.sv
source/lpif_wb_cfg.sv
source/lpif_link_top.sv
bench/lpif_link_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the link testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary -j 0 -f sim.f --top-module lpif_link_tb -o lpif_link_sim

./obj_dir/lpif_link_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
  echo "Simulation failed, see $LOG"
  exit 1
fi

if ! grep -q "TESTBENCH PASSED" "$LOG"; then
  echo "Simulation ended without a result, see $LOG"
  exit 1
fi

echo "Simulation passed"
